//--- Makefile
# Verilator flow, the run exits non-zero on any $fatal

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wno-fatal hw_mgr_cfg_pkg.sv hw_mgr_status_pkg.sv \
	  hw_fault_monitor.sv hw_power_sequencer.sv hw_status_reporter.sv \
	  hw_manager_top.sv --top-module hw_manager_top
	verilator --lint-only -Wno-fatal --timing --assert -f hw_manager_top.f \
	  --top-module tb_hw_manager

sim:
	verilator --binary -Wno-fatal --timing --assert -f hw_manager_top.f \
	  --top-module tb_hw_manager -o tb_hw_manager
	./obj_dir/tb_hw_manager

clean:
	rm -rf obj_dir

//--- hw_fault_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module hw_fault_monitor (
  input  logic                                sys_en,
  input  hw_mgr_status_pkg::prestart_faults_t prestart,
  input  hw_mgr_status_pkg::sys_faults_t      sys_faults,
  input  hw_mgr_status_pkg::board_faults_t    board_faults,
  input  hw_mgr_cfg_pkg::board_vec_t          dac_boot_fail,
  output hw_mgr_status_pkg::fault_report_t    prestart_report,
  output hw_mgr_status_pkg::fault_report_t    boot_report,
  output hw_mgr_status_pkg::fault_report_t    run_report
);
  import hw_mgr_status_pkg::*;

  // Valid report with the lowest offending board attached
  function automatic fault_report_t mk_report(
    input status_code_t               code,
    input hw_mgr_cfg_pkg::board_vec_t boards
  );
    return '{valid: 1'b1, code: code, board: lowest_board(boards)};
  endfunction

  // Config checks on the way out of IDLE
  always_comb begin
    prestart_report = '0;
    if (prestart.integ_thresh_avg_oob)
      prestart_report = mk_report(STS_INTEG_THRESH_AVG_OOB, '0);
    else if (prestart.integ_window_oob)
      prestart_report = mk_report(STS_INTEG_WINDOW_OOB, '0);
    else if (prestart.integ_en_oob)
      prestart_report = mk_report(STS_INTEG_EN_OOB, '0);
    else if (prestart.sys_en_oob)
      prestart_report = mk_report(STS_SYS_EN_OOB, '0);
  end

  // Only DAC boot is left in the boot group
  assign boot_report = (|dac_boot_fail) ? mk_report(STS_DAC_BOOT_FAIL, dac_boot_fail) : '0;

  // Faults watched in RUNNING
  always_comb begin
    run_report = '0;
    if (!sys_en)  // Power-down request beats everything
      run_report = mk_report(STS_PS_SHUTDOWN, '0);
    else if (sys_faults.lock_viol)
      run_report = mk_report(STS_LOCK_VIOL, '0);
    else if (|board_faults.shutdown_sense)
      run_report = mk_report(STS_SHUTDOWN_SENSE, board_faults.shutdown_sense);
    else if (sys_faults.ext_shutdown)
      run_report = mk_report(STS_EXT_SHUTDOWN, '0);
    else if (|board_faults.over_thresh)  // Integrator core
      run_report = mk_report(STS_OVER_THRESH, board_faults.over_thresh);
    else if (|board_faults.thresh_underflow)
      run_report = mk_report(STS_THRESH_UNDERFLOW, board_faults.thresh_underflow);
    else if (|board_faults.thresh_overflow)
      run_report = mk_report(STS_THRESH_OVERFLOW, board_faults.thresh_overflow);
    else if (|board_faults.bad_dac_cmd)  // DAC commands and buffers
      run_report = mk_report(STS_BAD_DAC_CMD, board_faults.bad_dac_cmd);
    else if (|board_faults.dac_cal_oob)
      run_report = mk_report(STS_DAC_CAL_OOB, board_faults.dac_cal_oob);
    else if (|board_faults.dac_val_oob)
      run_report = mk_report(STS_DAC_VAL_OOB, board_faults.dac_val_oob);
    else if (|board_faults.dac_cmd_buf_underflow)
      run_report = mk_report(STS_DAC_BUF_UNDERFLOW, board_faults.dac_cmd_buf_underflow);
    else if (|board_faults.dac_cmd_buf_overflow)
      run_report = mk_report(STS_DAC_BUF_OVERFLOW, board_faults.dac_cmd_buf_overflow);
    else if (|board_faults.unexp_dac_trig)
      run_report = mk_report(STS_UNEXP_DAC_TRIG, board_faults.unexp_dac_trig);
  end

  // A fault must never read back as OK in the status word
  always_comb begin
    assert ((!prestart_report.valid || prestart_report.code != STS_OK) &&
            (!boot_report.valid || boot_report.code != STS_OK) &&
            (!run_report.valid || run_report.code != STS_OK))
      else $error("valid fault report carries STS_OK");
  end

endmodule

`default_nettype wire

//--- hw_manager_top.f
hw_mgr_cfg_pkg.sv
hw_mgr_status_pkg.sv
hw_fault_monitor.sv
hw_power_sequencer.sv
hw_status_reporter.sv
hw_manager_top.sv
tb_hw_manager.sv

//--- hw_manager_top.sv
`timescale 1ns/100ps
`default_nettype none

module hw_manager_top #(
  parameter hw_mgr_cfg_pkg::timer_t SHUTDOWN_FORCE_DELAY = 32'd25_000_000,
  parameter hw_mgr_cfg_pkg::timer_t SHUTDOWN_RESET_PULSE = 32'd25_000,
  parameter hw_mgr_cfg_pkg::timer_t SHUTDOWN_RESET_DELAY = 32'd25_000_000,
  parameter hw_mgr_cfg_pkg::timer_t SPI_RESET_WAIT       = 32'd25_000_000,
  parameter hw_mgr_cfg_pkg::timer_t SPI_START_WAIT       = 32'd250_000_000
) (
  input  logic                                clk,
  input  logic                                aresetn,
  input  logic                                sys_en,
  input  logic                                spi_off,
  input  hw_mgr_status_pkg::prestart_faults_t prestart,
  input  hw_mgr_status_pkg::sys_faults_t      sys_faults,
  input  hw_mgr_status_pkg::board_faults_t    board_faults,
  input  hw_mgr_cfg_pkg::board_vec_t          dac_boot_fail,
  output logic                                unlock_cfg,
  output logic                                spi_clk_power_n,
  output logic                                spi_en,
  output logic                                shutdown_sense_en,
  output logic                                block_buffers,
  output logic                                n_shutdown_force,
  output logic                                n_shutdown_rst,
  output hw_mgr_status_pkg::status_word_t     status_word,
  output logic                                ps_interrupt
);
  import hw_mgr_cfg_pkg::*;
  import hw_mgr_status_pkg::*;

  fault_report_t prestart_report, boot_report, run_report;
  hw_state_e     state;
  logic          report_load, report_clear;
  report_sel_e   report_sel;

  hw_fault_monitor u_fault_monitor (
    .sys_en          (sys_en),
    .prestart        (prestart),
    .sys_faults      (sys_faults),
    .board_faults    (board_faults),
    .dac_boot_fail   (dac_boot_fail),
    .prestart_report (prestart_report),
    .boot_report     (boot_report),
    .run_report      (run_report)
  );

  hw_power_sequencer #(
    .SHUTDOWN_FORCE_DELAY (SHUTDOWN_FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (SHUTDOWN_RESET_DELAY),
    .SPI_RESET_WAIT       (SPI_RESET_WAIT),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) u_power_sequencer (
    .clk               (clk),
    .aresetn           (aresetn),
    .sys_en            (sys_en),
    .spi_off           (spi_off),
    .prestart_report   (prestart_report),
    .boot_report       (boot_report),
    .run_report        (run_report),
    .state             (state),
    .report_load       (report_load),
    .report_sel        (report_sel),
    .report_clear      (report_clear),
    .unlock_cfg        (unlock_cfg),
    .spi_clk_power_n   (spi_clk_power_n),
    .spi_en            (spi_en),
    .shutdown_sense_en (shutdown_sense_en),
    .block_buffers     (block_buffers),
    .n_shutdown_force  (n_shutdown_force),
    .n_shutdown_rst    (n_shutdown_rst)
  );

  hw_status_reporter u_status_reporter (
    .clk             (clk),
    .aresetn         (aresetn),
    .state           (state),
    .report_load     (report_load),
    .report_sel      (report_sel),
    .report_clear    (report_clear),
    .prestart_report (prestart_report),
    .boot_report     (boot_report),
    .run_report      (run_report),
    .status_word     (status_word),
    .ps_interrupt    (ps_interrupt)
  );

endmodule

`default_nettype wire

//--- hw_mgr_cfg_pkg.sv
`default_nettype none

package hw_mgr_cfg_pkg;

  // Amplifier boards in the system
  localparam int NUM_BOARDS  = 8;
  localparam int BOARD_IDX_W = $clog2(NUM_BOARDS);

  typedef logic [NUM_BOARDS-1:0]  board_vec_t;  // One bit per board
  typedef logic [BOARD_IDX_W-1:0] board_idx_t;  // Board number

  // Timeout counter, wide enough for the one second SPI start wait
  typedef logic [31:0] timer_t;

  // Cycles in CONFIRM_SPI_RST before spi_off is trusted
  localparam timer_t SPI_OFF_SETTLE = 32'd10;

  // Supervisor state, encoding is visible in the status word
  typedef enum logic [3:0] {
    IDLE              = 4'd1,
    CONFIRM_SPI_RST   = 4'd2,
    POWER_ON_CTRL_BRD = 4'd3,
    CONFIRM_SPI_START = 4'd4,
    POWER_ON_AMP_BRD  = 4'd5,
    AMP_POWER_WAIT    = 4'd6,
    RUNNING           = 4'd7,
    HALTING           = 4'd8,
    HALTED            = 4'd9
  } hw_state_e;

endpackage

`default_nettype wire

//--- hw_mgr_status_pkg.sv
`default_nettype none

package hw_mgr_status_pkg;

  typedef logic [24:0] status_code_t;

  // Basic system
  localparam status_code_t STS_OK                   = 25'h001;
  localparam status_code_t STS_PS_SHUTDOWN          = 25'h002;
  // SPI subsystem
  localparam status_code_t STS_SPI_START_TIMEOUT    = 25'h100;
  localparam status_code_t STS_SPI_RESET_TIMEOUT    = 25'h101;
  // Pre-start configuration
  localparam status_code_t STS_INTEG_THRESH_AVG_OOB = 25'h200;
  localparam status_code_t STS_INTEG_WINDOW_OOB     = 25'h201;
  localparam status_code_t STS_INTEG_EN_OOB         = 25'h202;
  localparam status_code_t STS_SYS_EN_OOB           = 25'h203;
  localparam status_code_t STS_LOCK_VIOL            = 25'h204;
  // Shutdown
  localparam status_code_t STS_SHUTDOWN_SENSE       = 25'h300;
  localparam status_code_t STS_EXT_SHUTDOWN         = 25'h301;
  // Integrator threshold core
  localparam status_code_t STS_OVER_THRESH          = 25'h400;
  localparam status_code_t STS_THRESH_UNDERFLOW     = 25'h401;
  localparam status_code_t STS_THRESH_OVERFLOW      = 25'h402;
  // DAC boot, commands and buffers
  localparam status_code_t STS_DAC_BOOT_FAIL        = 25'h600;
  localparam status_code_t STS_BAD_DAC_CMD          = 25'h601;
  localparam status_code_t STS_DAC_CAL_OOB          = 25'h602;
  localparam status_code_t STS_DAC_VAL_OOB          = 25'h603;
  localparam status_code_t STS_DAC_BUF_UNDERFLOW    = 25'h604;
  localparam status_code_t STS_DAC_BUF_OVERFLOW     = 25'h605;
  localparam status_code_t STS_UNEXP_DAC_TRIG       = 25'h606;

  // Config flags checked before start, highest priority first
  typedef struct packed {
    logic integ_thresh_avg_oob;
    logic integ_window_oob;
    logic integ_en_oob;
    logic sys_en_oob;
  } prestart_faults_t;

  // System wide faults while running
  typedef struct packed {
    logic lock_viol;     // Config written while locked
    logic ext_shutdown;  // External shutdown request
  } sys_faults_t;

  // Per-board faults in priority order
  typedef struct packed {
    hw_mgr_cfg_pkg::board_vec_t shutdown_sense;
    hw_mgr_cfg_pkg::board_vec_t over_thresh;
    hw_mgr_cfg_pkg::board_vec_t thresh_underflow;
    hw_mgr_cfg_pkg::board_vec_t thresh_overflow;
    hw_mgr_cfg_pkg::board_vec_t bad_dac_cmd;
    hw_mgr_cfg_pkg::board_vec_t dac_cal_oob;
    hw_mgr_cfg_pkg::board_vec_t dac_val_oob;
    hw_mgr_cfg_pkg::board_vec_t dac_cmd_buf_underflow;
    hw_mgr_cfg_pkg::board_vec_t dac_cmd_buf_overflow;
    hw_mgr_cfg_pkg::board_vec_t unexp_dac_trig;
  } board_faults_t;

  typedef struct packed {
    logic                       valid;
    status_code_t               code;
    hw_mgr_cfg_pkg::board_idx_t board;  // Zero for system wide faults
  } fault_report_t;

  // Register view for the processor
  typedef struct packed {
    hw_mgr_cfg_pkg::board_idx_t board;
    status_code_t               code;
    hw_mgr_cfg_pkg::hw_state_e  state;
  } status_word_t;

  // Which report the status registers take on a load
  typedef enum logic [2:0] {
    SEL_PRESTART     = 3'd0,
    SEL_BOOT         = 3'd1,
    SEL_RUN          = 3'd2,
    SEL_SPI_RST_TO   = 3'd3,
    SEL_SPI_START_TO = 3'd4
  } report_sel_e;

  // Lowest set board, zero when none
  function automatic hw_mgr_cfg_pkg::board_idx_t lowest_board(
    input hw_mgr_cfg_pkg::board_vec_t boards
  );
    hw_mgr_cfg_pkg::board_idx_t idx;
    idx = '0;
    for (int i = hw_mgr_cfg_pkg::NUM_BOARDS - 1; i >= 0; i--) begin
      if (boards[i]) idx = hw_mgr_cfg_pkg::board_idx_t'(i);  // Last hit wins
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

//--- hw_power_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module hw_power_sequencer #(
  parameter hw_mgr_cfg_pkg::timer_t SHUTDOWN_FORCE_DELAY = 32'd25_000_000,  // 100 ms at 250 MHz
  parameter hw_mgr_cfg_pkg::timer_t SHUTDOWN_RESET_PULSE = 32'd25_000,      // 100 us
  parameter hw_mgr_cfg_pkg::timer_t SHUTDOWN_RESET_DELAY = 32'd25_000_000,  // 100 ms
  parameter hw_mgr_cfg_pkg::timer_t SPI_RESET_WAIT       = 32'd25_000_000,  // 100 ms
  parameter hw_mgr_cfg_pkg::timer_t SPI_START_WAIT       = 32'd250_000_000  // 1 s
) (
  input  logic                             clk,
  input  logic                             aresetn,
  input  logic                             sys_en,
  input  logic                             spi_off,
  input  hw_mgr_status_pkg::fault_report_t prestart_report,
  input  hw_mgr_status_pkg::fault_report_t boot_report,
  input  hw_mgr_status_pkg::fault_report_t run_report,
  output hw_mgr_cfg_pkg::hw_state_e        state,
  output logic                             report_load,
  output hw_mgr_status_pkg::report_sel_e   report_sel,
  output logic                             report_clear,
  output logic                             unlock_cfg,
  output logic                             spi_clk_power_n,
  output logic                             spi_en,
  output logic                             shutdown_sense_en,
  output logic                             block_buffers,
  output logic                             n_shutdown_force,
  output logic                             n_shutdown_rst
);
  import hw_mgr_cfg_pkg::*;
  import hw_mgr_status_pkg::*;

  // Power and SPI controls, all registered
  typedef struct packed {
    logic unlock_cfg;
    logic spi_clk_power_n;
    logic spi_en;
    logic shutdown_sense_en;
    logic block_buffers;
    logic n_shutdown_force;
    logic n_shutdown_rst;
  } ctrl_t;

  // Everything off, config open, buffers blocked
  localparam ctrl_t CTRL_SAFE = '{
    unlock_cfg: 1'b1, spi_clk_power_n: 1'b1, spi_en: 1'b0, shutdown_sense_en: 1'b0,
    block_buffers: 1'b1, n_shutdown_force: 1'b0, n_shutdown_rst: 1'b1
  };

  hw_state_e state_d;
  timer_t    timer_q, timer_d;
  ctrl_t     ctrl_q, ctrl_d;

  always_comb begin
    state_d      = state;
    timer_d      = '0;         // Only timed states count
    ctrl_d       = ctrl_q;
    report_load  = 1'b0;
    report_sel   = SEL_RUN;
    report_clear = 1'b0;
    case (state)
      IDLE: begin
        if (sys_en) begin
          if (prestart_report.valid) begin  // Bad config, never power up
            state_d     = HALTING;
            report_load = 1'b1;
            report_sel  = SEL_PRESTART;
          end else begin
            state_d                = CONFIRM_SPI_RST;
            ctrl_d.unlock_cfg      = 1'b0;  // Lock config
            ctrl_d.spi_clk_power_n = 1'b0;  // SPI clock on
          end
        end
      end
      CONFIRM_SPI_RST: begin
        timer_d = timer_q + 1'b1;
        if (timer_q >= SPI_OFF_SETTLE && spi_off) begin
          state_d                 = POWER_ON_CTRL_BRD;
          ctrl_d.spi_clk_power_n  = 1'b1;
          ctrl_d.n_shutdown_force = 1'b1;  // Release shutdown force
        end else if (timer_q >= SPI_RESET_WAIT) begin
          state_d     = HALTING;
          report_load = 1'b1;
          report_sel  = SEL_SPI_RST_TO;
        end
      end
      POWER_ON_CTRL_BRD: begin
        timer_d = timer_q + 1'b1;
        if (timer_q >= SHUTDOWN_FORCE_DELAY) begin  // Converters had time to come up
          state_d                  = CONFIRM_SPI_START;
          ctrl_d.shutdown_sense_en = 1'b1;
          ctrl_d.spi_en            = 1'b1;
          ctrl_d.spi_clk_power_n   = 1'b0;
        end
      end
      CONFIRM_SPI_START: begin
        timer_d = timer_q + 1'b1;
        if (!spi_off) begin
          state_d               = POWER_ON_AMP_BRD;
          ctrl_d.n_shutdown_rst = 1'b0;  // Start reset pulse
        end else if (boot_report.valid) begin
          state_d     = HALTING;
          report_load = 1'b1;
          report_sel  = SEL_BOOT;
        end else if (timer_q >= SPI_START_WAIT) begin
          state_d     = HALTING;
          report_load = 1'b1;
          report_sel  = SEL_SPI_START_TO;
        end
      end
      POWER_ON_AMP_BRD: begin
        timer_d = timer_q + 1'b1;
        if (timer_q >= SHUTDOWN_RESET_PULSE) begin
          state_d               = AMP_POWER_WAIT;
          ctrl_d.n_shutdown_rst = 1'b1;
        end
      end
      AMP_POWER_WAIT: begin
        timer_d = timer_q + 1'b1;
        if (timer_q >= SHUTDOWN_RESET_DELAY) begin
          state_d              = RUNNING;
          ctrl_d.block_buffers = 1'b0;  // Let commands and data through
        end
      end
      RUNNING: begin
        if (run_report.valid) begin  // Checked from the first cycle
          state_d     = HALTING;
          report_load = 1'b1;
          report_sel  = SEL_RUN;
        end
      end
      HALTING: begin
        state_d = HALTED;
        ctrl_d  = CTRL_SAFE;
      end
      HALTED: begin
        if (!sys_en) begin  // Processor acknowledged by dropping enable
          state_d      = IDLE;
          report_clear = 1'b1;
        end
      end
      default: state_d = HALTED;
    endcase
    if (state_d != state) timer_d = '0;  // Fresh count per state
  end

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state   <= IDLE;
      timer_q <= '0;
      ctrl_q  <= CTRL_SAFE;
    end else begin
      state   <= state_d;
      timer_q <= timer_d;
      ctrl_q  <= ctrl_d;
    end
  end

  assign unlock_cfg        = ctrl_q.unlock_cfg;
  assign spi_clk_power_n   = ctrl_q.spi_clk_power_n;
  assign spi_en            = ctrl_q.spi_en;
  assign shutdown_sense_en = ctrl_q.shutdown_sense_en;
  assign block_buffers     = ctrl_q.block_buffers;
  assign n_shutdown_force  = ctrl_q.n_shutdown_force;
  assign n_shutdown_rst    = ctrl_q.n_shutdown_rst;

  // Reset pulse confined to its state
  a_rst_pulse_state: assert property (@(posedge clk) disable iff (!aresetn)
    !n_shutdown_rst |-> state == POWER_ON_AMP_BRD);

  // Buffers open only while running, HALTING is the one cycle on the way out
  a_buffers_running: assert property (@(posedge clk) disable iff (!aresetn)
    !block_buffers |-> state inside {RUNNING, HALTING});

endmodule

`default_nettype wire

//--- hw_status_reporter.sv
`timescale 1ns/100ps
`default_nettype none

module hw_status_reporter (
  input  logic                             clk,
  input  logic                             aresetn,
  input  hw_mgr_cfg_pkg::hw_state_e        state,
  input  logic                             report_load,
  input  hw_mgr_status_pkg::report_sel_e   report_sel,
  input  logic                             report_clear,
  input  hw_mgr_status_pkg::fault_report_t prestart_report,
  input  hw_mgr_status_pkg::fault_report_t boot_report,
  input  hw_mgr_status_pkg::fault_report_t run_report,
  output hw_mgr_status_pkg::status_word_t  status_word,
  output logic                             ps_interrupt
);
  import hw_mgr_cfg_pkg::*;
  import hw_mgr_status_pkg::*;

  status_code_t  code_q;
  board_idx_t    board_q;
  hw_state_e     state_q;     // State one cycle back
  fault_report_t sel_report;

  // Timeouts carry no board
  always_comb begin
    case (report_sel)
      SEL_PRESTART:     sel_report = prestart_report;
      SEL_BOOT:         sel_report = boot_report;
      SEL_SPI_RST_TO:   sel_report = '{valid: 1'b1, code: STS_SPI_RESET_TIMEOUT, board: '0};
      SEL_SPI_START_TO: sel_report = '{valid: 1'b1, code: STS_SPI_START_TIMEOUT, board: '0};
      default:          sel_report = run_report;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      code_q  <= STS_OK;
      board_q <= '0;
      state_q <= IDLE;
    end else begin
      state_q <= state;
      if (report_clear) begin
        code_q  <= STS_OK;
        board_q <= '0;
      end else if (report_load) begin
        code_q  <= sel_report.code;
        board_q <= sel_report.board;
      end
    end
  end

  assign status_word = '{board: board_q, code: code_q, state: state};

  // Interrupt on arrival in RUNNING or HALTED
  assign ps_interrupt = (state != state_q) && (state == RUNNING || state == HALTED);

  a_irq_single: assert property (@(posedge clk) disable iff (!aresetn)
    ps_interrupt |=> !ps_interrupt);

endmodule

`default_nettype wire

//--- tb_hw_manager.sv
`timescale 1ns/100ps
`default_nettype none

module tb_hw_manager;
  import hw_mgr_cfg_pkg::*;
  import hw_mgr_status_pkg::*;

  // Short timings, a full power-up takes about 70 cycles
  localparam timer_t FORCE_DELAY    = 32'd20;
  localparam timer_t RESET_PULSE    = 32'd4;
  localparam timer_t RESET_DELAY    = 32'd20;
  localparam timer_t SPI_RST_WAIT   = 32'd40;
  localparam timer_t SPI_START_WAIT = 32'd60;

  localparam int RESET_CYCLES = 16;
  localparam int STATE_WAIT   = 200;  // Longest single wait is the SPI start timeout
  localparam int NUM_RUNS     = 30;   // 1 + 4 + 2 + 1 + 20 + 2 power-up attempts
  localparam int RUN_BUDGET   = 133;  // Power-up, halt and return to IDLE with margin
  localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_RUNS * RUN_BUDGET;

  // Control outputs in port order
  typedef struct packed {
    logic unlock_cfg;
    logic spi_clk_power_n;
    logic spi_en;
    logic shutdown_sense_en;
    logic block_buffers;
    logic n_shutdown_force;
    logic n_shutdown_rst;
  } ctrl_levels_t;

  localparam ctrl_levels_t CTRL_SAFE = 7'b1100101;  // Reset and HALTED levels
  localparam ctrl_levels_t CTRL_RUN  = 7'b0011011;  // Config locked, SPI on, buffers open

  // How the SPI model answers
  typedef enum logic [1:0] {SPI_FOLLOW, SPI_STUCK_LOW, SPI_STUCK_HIGH} spi_mode_e;

  logic             clk = 1'b0;
  logic             aresetn;
  logic             sys_en;
  logic             spi_off = 1'b1;
  prestart_faults_t prestart;
  sys_faults_t      sys_faults;
  board_faults_t    board_faults;
  board_vec_t       dac_boot_fail;
  logic             unlock_cfg;
  logic             spi_clk_power_n;
  logic             spi_en;
  logic             shutdown_sense_en;
  logic             block_buffers;
  logic             n_shutdown_force;
  logic             n_shutdown_rst;
  status_word_t     status_word;
  logic             ps_interrupt;

  spi_mode_e    spi_mode;
  status_word_t exp_halt;            // What HALTED must show
  int           irq_count = 0;
  int           rst_low_cycles = 0;  // Cycles seen with n_shutdown_rst low
  int           cycles = 0;
  logic [31:0]  lfsr_q = 32'h21d3_724f;

  hw_manager_top #(
    .SHUTDOWN_FORCE_DELAY (FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (RESET_DELAY),
    .SPI_RESET_WAIT       (SPI_RST_WAIT),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) u_dut (
    .clk               (clk),
    .aresetn           (aresetn),
    .sys_en            (sys_en),
    .spi_off           (spi_off),
    .prestart          (prestart),
    .sys_faults        (sys_faults),
    .board_faults      (board_faults),
    .dac_boot_fail     (dac_boot_fail),
    .unlock_cfg        (unlock_cfg),
    .spi_clk_power_n   (spi_clk_power_n),
    .spi_en            (spi_en),
    .shutdown_sense_en (shutdown_sense_en),
    .block_buffers     (block_buffers),
    .n_shutdown_force  (n_shutdown_force),
    .n_shutdown_rst    (n_shutdown_rst),
    .status_word       (status_word),
    .ps_interrupt      (ps_interrupt)
  );

  always #4 clk = ~clk;  // 8 ns period

  // SPI subsystem stays off until enabled, unless forced
  always @(posedge clk) begin
    case (spi_mode)
      SPI_STUCK_LOW:  spi_off <= 1'b0;
      SPI_STUCK_HIGH: spi_off <= 1'b1;
      default:        spi_off <= !spi_en;
    endcase
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
      abort_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic board_idx_t first_set_board(input board_vec_t v);
    for (int i = 0; i < NUM_BOARDS; i++) begin
      if (v[i]) return board_idx_t'(i);
    end
    return '0;
  endfunction

  // Pre-start flags, MSB is the highest priority
  function automatic fault_report_t predict_prestart(input prestart_faults_t p);
    status_code_t  codes [4];
    logic [3:0]    flags;
    fault_report_t r;
    codes = '{STS_SYS_EN_OOB, STS_INTEG_EN_OOB, STS_INTEG_WINDOW_OOB,
              STS_INTEG_THRESH_AVG_OOB};
    flags = p;
    r     = '0;
    for (int i = 3; i >= 0; i--) begin
      if (!r.valid && flags[i]) r = '{valid: 1'b1, code: codes[i], board: '0};
    end
    return r;
  endfunction

  // Running faults, table index 0 wins, system faults report board 0
  function automatic fault_report_t predict_run(input logic en, input sys_faults_t sf,
                                                input board_faults_t bf);
    status_code_t  codes [13];
    board_vec_t    hits  [13];
    fault_report_t r;
    codes = '{STS_PS_SHUTDOWN, STS_LOCK_VIOL, STS_SHUTDOWN_SENSE, STS_EXT_SHUTDOWN,
              STS_OVER_THRESH, STS_THRESH_UNDERFLOW, STS_THRESH_OVERFLOW,
              STS_BAD_DAC_CMD, STS_DAC_CAL_OOB, STS_DAC_VAL_OOB,
              STS_DAC_BUF_UNDERFLOW, STS_DAC_BUF_OVERFLOW, STS_UNEXP_DAC_TRIG};
    hits  = '{board_vec_t'(!en), board_vec_t'(sf.lock_viol), bf.shutdown_sense,
              board_vec_t'(sf.ext_shutdown), bf.over_thresh, bf.thresh_underflow,
              bf.thresh_overflow, bf.bad_dac_cmd, bf.dac_cal_oob, bf.dac_val_oob,
              bf.dac_cmd_buf_underflow, bf.dac_cmd_buf_overflow, bf.unexp_dac_trig};
    r = '0;
    for (int i = 0; i < 13; i++) begin
      if (!r.valid && hits[i] != '0)
        r = '{valid: 1'b1, code: codes[i], board: first_set_board(hits[i])};
    end
    return r;
  endfunction

  // Each field hit about one time in four, never all clear
  function automatic board_faults_t random_board_faults();
    logic [79:0] raw;
    board_vec_t  v;
    raw = '0;
    for (int f = 0; f < 10; f++) begin
      if (rand_bits(2) == 32'd3) raw[f*8 +: 8] = 8'(rand_bits(8));
    end
    if (raw == '0) begin
      v        = 8'(rand_bits(8));
      raw[7:0] = (v == '0) ? 8'h80 : v;  // unexp_dac_trig is the low field
    end
    return raw;
  endfunction

  function automatic string status_text(input status_word_t s);
    return $sformatf("board %0d code %h state %0d", s.board, s.code, s.state);
  endfunction

  function automatic ctrl_levels_t ctrl_now();
    return {unlock_cfg, spi_clk_power_n, spi_en, shutdown_sense_en,
            block_buffers, n_shutdown_force, n_shutdown_rst};
  endfunction

  task automatic check_status(input status_word_t got, input status_word_t exp,
                              input string what);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: %s status %s, expected %s",
                          $time, what, status_text(got), status_text(exp)));
  endtask

  task automatic check_ctrl(input ctrl_levels_t got, input ctrl_levels_t exp,
                            input string what);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: %s controls %b, expected %b",
                          $time, what, got, exp));
  endtask

  task automatic expect_irqs(input int n, input string what);
    if (irq_count != n)
      abort_run($sformatf("mismatch at %0t: %0d interrupts after %s, expected %0d",
                          $time, irq_count, what, n));
  endtask

  // Level checks in the settled states, mid-cycle
  always @(negedge clk) begin
    if (aresetn) begin
      if (ps_interrupt) irq_count++;
      if (!n_shutdown_rst) rst_low_cycles++;
      case (status_word.state)
        IDLE: begin
          check_status(status_word, '{board: '0, code: STS_OK, state: IDLE}, "IDLE");
          check_ctrl(ctrl_now(), CTRL_SAFE, "IDLE");
        end
        RUNNING: begin
          check_status(status_word, '{board: '0, code: STS_OK, state: RUNNING}, "RUNNING");
          check_ctrl(ctrl_now(), CTRL_RUN, "RUNNING");
        end
        HALTED: begin
          check_status(status_word, exp_halt, "HALTED");
          check_ctrl(ctrl_now(), CTRL_SAFE, "HALTED");
        end
        default: ;
      endcase
    end
  end

  task automatic wait_state(input hw_state_e target, input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > STATE_WAIT)
        abort_run($sformatf("%s not reached within %0d cycles", what, STATE_WAIT));
    end while (status_word.state != target);
  endtask

  task automatic power_up();
    @(posedge clk);
    sys_en <= 1'b1;
    wait_state(RUNNING, "RUNNING after power-up");
  endtask

  // Drop sys_en and all faults, HALTED falls back to IDLE
  task automatic recover(input int irq_exp);
    spi_mode = SPI_FOLLOW;
    @(posedge clk);
    sys_en        <= 1'b0;
    prestart      <= '0;
    sys_faults    <= '0;
    board_faults  <= '0;
    dac_boot_fail <= '0;
    wait_state(IDLE, "IDLE after sys_en dropped");
    expect_irqs(irq_exp, "halt");
  endtask

  task automatic run_fault(input logic en, input sys_faults_t sf, input board_faults_t bf);
    fault_report_t r;
    int            irq0;
    irq0 = irq_count;
    power_up();
    r        = predict_run(en, sf, bf);
    exp_halt = '{board: r.board, code: r.code, state: HALTED};
    @(posedge clk);
    sys_en       <= en;
    sys_faults   <= sf;
    board_faults <= bf;
    wait_state(HALTED, "HALTED after running fault");
    recover(irq0 + 2);  // RUNNING entry plus HALTED entry
  endtask

  task automatic spi_timeout(input spi_mode_e mode, input status_code_t code);
    int irq0;
    irq0     = irq_count;
    spi_mode = mode;
    exp_halt = '{board: '0, code: code, state: HALTED};
    @(posedge clk);
    sys_en <= 1'b1;
    wait_state(HALTED, "HALTED after SPI timeout");
    recover(irq0 + 1);
  endtask

  initial begin
    fault_report_t    r;
    prestart_faults_t p;
    sys_faults_t      sf;
    board_faults_t    bf;
    board_vec_t       b;
    int               irq0;
    int               rst0;
    aresetn       = 1'b0;
    sys_en        = 1'b0;
    prestart      = '0;
    sys_faults    = '0;
    board_faults  = '0;
    dac_boot_fail = '0;
    spi_mode      = SPI_FOLLOW;
    exp_halt      = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    aresetn <= 1'b1;

    // Normal power-up, then a plain shutdown
    irq0 = irq_count;
    rst0 = rst_low_cycles;
    power_up();
    @(negedge clk);
    if (rst_low_cycles - rst0 != int'(RESET_PULSE) + 1)
      abort_run($sformatf("mismatch at %0t: n_shutdown_rst low %0d cycles, expected %0d",
                          $time, rst_low_cycles - rst0, int'(RESET_PULSE) + 1));
    expect_irqs(irq0 + 1, "power-up");
    exp_halt = '{board: '0, code: STS_PS_SHUTDOWN, state: HALTED};
    recover(irq0 + 2);

    // Bad config never leaves IDLE for the power-up
    repeat (4) begin
      p = 4'(rand_bits(4));
      if (p == '0) p = 4'b0011;
      r        = predict_prestart(p);
      exp_halt = '{board: r.board, code: r.code, state: HALTED};
      irq0     = irq_count;
      @(posedge clk);
      prestart <= p;
      sys_en   <= 1'b1;
      wait_state(HALTED, "HALTED after pre-start check");
      recover(irq0 + 1);
    end

    spi_timeout(SPI_STUCK_LOW, STS_SPI_RESET_TIMEOUT);
    spi_timeout(SPI_STUCK_HIGH, STS_SPI_START_TIMEOUT);

    // DAC boot failure while SPI start is still pending
    irq0     = irq_count;
    spi_mode = SPI_STUCK_HIGH;
    b        = 8'(rand_bits(8));
    if (b == '0) b = 8'h40;
    exp_halt = '{board: first_set_board(b), code: STS_DAC_BOOT_FAIL, state: HALTED};
    @(posedge clk);
    sys_en <= 1'b1;
    wait_state(CONFIRM_SPI_START, "CONFIRM_SPI_START");
    @(posedge clk);
    dac_boot_fail <= b;
    wait_state(HALTED, "HALTED after DAC boot failure");
    recover(irq0 + 1);

    repeat (20) begin
      sf.lock_viol    = (rand_bits(3) == 32'd0);  // Rare, it masks most others
      sf.ext_shutdown = (rand_bits(2) == 32'd0);
      bf              = random_board_faults();
      run_fault(1'b1, sf, bf);
    end

    // Shutdown request beats every other fault
    sf.lock_viol    = 1'b1;
    sf.ext_shutdown = 1'b1;
    bf              = random_board_faults();
    run_fault(1'b0, sf, bf);
    sf.ext_shutdown = 1'b0;
    run_fault(1'b1, sf, '0);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
